// ==== tlb_entry.f ====
design/tlb_pkg.sv
design/tlb_op_pkg.sv
design/tlb_way_if.sv
design/tlb_lutram.sv
design/tlb_set_counter.sv
design/tlb_inv_fsm.sv
design/tlb_search.sv
design/tlb_entry.sv
verification/tb_tlb_entry.sv

// ==== Makefile ====
# Verilator build and run of the TLB testbench

TOP := tb_tlb_entry

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) --Mdir obj_dir -f tlb_entry.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null

clean:
	rm -rf obj_dir

// ==== verification/tlb_stim.txt ====
# W idx e vppn ps g asid ppn0 attr0 ppn1 attr1 rnd / R idx / Z  (all hex, attr = plv mat d v)
# S port vppn odd asid found idx / I op asid vpn widx  (port 2 = both, widx 20 = no write)
Z
W 03 1 12343 c 0 055 abcde 1b 13579 2d 0
W 0b 1 2a003 15 1 100 0 1e 0 21 1
W 15 1 00015 c 0 055 0 03 0 03 1
W 1f 1 7ff0f c 1 3ff 0badc 2a 54321 17 0
W 00 0 00000 c 0 000 11111 03 22222 03 0
R 03
R 0b
R 15
R 1f
R 00
S 2 12343 0 055 1 03
S 0 12343 1 055 1 03
S 1 12343 0 056 0 00
S 0 12353 0 055 0 00
S 1 2a1f3 1 3ff 1 0b
S 0 2a0a3 0 000 1 0b
S 2 00000 0 000 0 00
S 0 7ff0f 1 123 1 1f
I 5 055 12343 20
S 0 12343 0 055 0 00
I 6 200 2a1f3 20
S 1 2a0a3 0 000 0 00
I 4 055 0 20
S 0 00015 0 055 0 00
W 03 1 12343 c 0 055 abcde 1b 13579 2d 0
I 3 000 0 03
S 2 12343 0 055 1 03
I 2 000 0 20
S 0 7ff0f 1 123 0 00
I 1 000 0 20
S 0 12343 0 055 0 00
I 0 000 0 20
Z
R 03

// ==== verification/tb_tlb_entry.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_tlb_entry;
    import tlb_pkg::*;
    import tlb_op_pkg::*;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        s0_fetch_i;
    logic [18:0] s0_vppn_i;
    logic        s0_odd_page_i;
    logic [9:0]  s0_asid_i;
    logic        s0_found_o;
    logic [4:0]  s0_index_o;
    logic [5:0]  s0_ps_o;
    logic [19:0] s0_ppn_o;
    logic        s0_v_o;
    logic        s0_d_o;
    logic [1:0]  s0_mat_o;
    logic [1:0]  s0_plv_o;
    logic        s1_fetch_i;
    logic [18:0] s1_vppn_i;
    logic        s1_odd_page_i;
    logic [9:0]  s1_asid_i;
    logic        s1_found_o;
    logic [4:0]  s1_index_o;
    logic [5:0]  s1_ps_o;
    logic [19:0] s1_ppn_o;
    logic        s1_v_o;
    logic        s1_d_o;
    logic [1:0]  s1_mat_o;
    logic [1:0]  s1_plv_o;
    logic        we_i;
    logic [4:0]  w_index_i;
    tlb_entry_t  w_entry_i;
    logic [4:0]  r_index_i;
    tlb_entry_t  r_entry_o;
    logic        inv_en_i;
    inv_op_e     inv_op_i;
    logic [9:0]  inv_asid_i;
    logic [18:0] inv_vpn_i;
    logic        stall_o;

    tlb_entry_t model [tlb_num];
    logic       written [tlb_num];  // lutram data is only known once written
    int         n_checks = 0;
    int         n_errors = 0;
    int         n_lines = 0;
    integer     seed = 32'hc841_db10;

    tlb_entry i_dut (.*);

    always #20 clk = ~clk;

    // 4 KB pages compare all of vppn, 2 MB pages only vppn[18:9]
    function automatic logic va_hit(tlb_data_t d, logic [18:0] vpn);
        if (d.ps == 6'd12) begin
            return d.vppn == vpn;
        end
        return (d.ps == 6'd21) && (d.vppn[18:9] == vpn[18:9]);
    endfunction

    function automatic logic clears(tlb_data_t d, logic [4:0] op, logic [9:0] asid,
                                    logic [18:0] vpn);
        logic own;
        own = (d.asid == asid);
        case (op)
            5'd0, 5'd1: return 1'b1;
            5'd2:       return d.g;
            5'd3:       return !d.g;
            5'd4:       return !d.g && own;
            5'd5:       return !d.g && own && va_hit(d, vpn);
            5'd6:       return (d.g || own) && va_hit(d, vpn);
            default:    return 1'b0;
        endcase
    endfunction

    function automatic tlb_half_t make_half(logic [31:0] ppn, logic [31:0] attr);
        tlb_half_t h;
        h.ppn = ppn[19:0];
        h.plv = attr[5:4];
        h.mat = attr[3:2];
        h.d   = attr[1];
        h.v   = attr[0];
        return h;
    endfunction

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic expect_fields(int got, int want, logic [7:0] cmd);
        if (got != want) begin
            n_errors++;
            $display("stimulus line %c has %0d fields where %0d are needed", cmd, got, want);
        end
    endtask

    task automatic read_check(logic [4:0] idx);
        @(posedge clk);
        r_index_i <= idx;
        @(negedge clk);
        check("r_entry_o.e", 128'(model[idx].e), 128'(r_entry_o.e));
        if (written[idx]) begin
            check("r_entry_o.data", 128'(model[idx].data), 128'(r_entry_o.data));
        end
    endtask

    task automatic read_all();
        for (int i = 0; i < tlb_num; i++) begin
            read_check(5'(i));
        end
    endtask

    task automatic do_write(logic [4:0] idx, tlb_entry_t ent);
        @(posedge clk);
        we_i      <= 1'b1;
        w_index_i <= idx;
        w_entry_i <= ent;
        @(posedge clk);
        we_i <= 1'b0;
        model[idx]   = ent;
        written[idx] = 1'b1;
    endtask

    task automatic check_port(int p, logic exp_found, logic [4:0] exp_idx, logic odd,
                              logic [18:0] vppn);
        tlb_data_t d;
        tlb_half_t h;
        string     pre;
        d   = model[exp_idx].data;
        h   = ((d.ps == 6'd12) ? odd : vppn[8]) ? d.half1 : d.half0;
        pre = (p == 1) ? "s1_" : "s0_";
        check({pre, "found_o"}, 128'(exp_found), 128'((p == 1) ? s1_found_o : s0_found_o));
        if (exp_found) begin
            check({pre, "index_o"}, 128'(exp_idx), 128'((p == 1) ? s1_index_o : s0_index_o));
            check({pre, "ps_o"}, 128'(d.ps), 128'((p == 1) ? s1_ps_o : s0_ps_o));
            check({pre, "ppn_o"}, 128'(h.ppn), 128'((p == 1) ? s1_ppn_o : s0_ppn_o));
            check({pre, "v_o"}, 128'(h.v), 128'((p == 1) ? s1_v_o : s0_v_o));
            check({pre, "d_o"}, 128'(h.d), 128'((p == 1) ? s1_d_o : s0_d_o));
            check({pre, "mat_o"}, 128'(h.mat), 128'((p == 1) ? s1_mat_o : s0_mat_o));
            check({pre, "plv_o"}, 128'(h.plv), 128'((p == 1) ? s1_plv_o : s0_plv_o));
        end
    endtask

    task automatic do_search(int port, logic [18:0] vppn, logic odd, logic [9:0] asid,
                             logic exp_found, logic [4:0] exp_idx);
        @(posedge clk);
        if (port != 1) begin
            s0_fetch_i    <= 1'b1;
            s0_vppn_i     <= vppn;
            s0_odd_page_i <= odd;
            s0_asid_i     <= asid;
        end
        if (port != 0) begin
            s1_fetch_i    <= 1'b1;
            s1_vppn_i     <= vppn;
            s1_odd_page_i <= odd;
            s1_asid_i     <= asid;
        end
        @(posedge clk);
        s0_fetch_i <= 1'b0;
        s1_fetch_i <= 1'b0;
        s0_vppn_i  <= ~vppn;  // result must hold without a fetch
        s1_vppn_i  <= ~vppn;
        s0_asid_i  <= ~asid;
        s1_asid_i  <= ~asid;
        repeat (2) begin
            @(negedge clk);
            if (port != 1) check_port(0, exp_found, exp_idx, odd, vppn);
            if (port != 0) check_port(1, exp_found, exp_idx, odd, vppn);
        end
    endtask

    task automatic do_inval(logic [4:0] op, logic [9:0] asid, logic [18:0] vpn,
                            logic [5:0] widx);
        tlb_entry_t keep;
        logic       do_wr;
        int         stalls;
        do_wr  = !widx[5];
        keep   = model[widx[4:0]];
        keep.e = 1'b1;
        stalls = 0;
        @(posedge clk);
        inv_en_i   <= 1'b1;
        inv_op_i   <= inv_op_e'(op);
        inv_asid_i <= asid;
        inv_vpn_i  <= vpn;
        w_index_i  <= widx[4:0];
        w_entry_i  <= keep;
        we_i       <= do_wr && (widx[2:0] == 3'd0);
        @(negedge clk);
        while (stall_o && stalls < 2 * sweep_len) begin
            stalls++;
            @(posedge clk);
            we_i <= do_wr && (stalls == int'(widx[2:0]));  // same edge as its set's clear
            @(negedge clk);
        end
        check("stall_o cycles", 128'(stalls), 128'(sweep_len));
        @(negedge clk);
        check("stall_o", 128'(1'b0), 128'(stall_o));  // no second sweep
        @(posedge clk);
        inv_en_i <= 1'b0;
        for (int i = 0; i < tlb_num; i++) begin
            if (clears(model[i].data, op, asid, vpn)) begin
                model[i].e = 1'b0;
            end
        end
        if (do_wr) begin
            model[widx[4:0]] = keep;
        end
        read_all();
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n_i    <= 1'b0;
        s0_fetch_i <= 1'b0;
        s1_fetch_i <= 1'b0;
        we_i       <= 1'b0;
        inv_en_i   <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        for (int i = 0; i < tlb_num; i++) begin
            model[i].e = 1'b0;
        end
        @(negedge clk);
        check("stall_o", 128'(1'b0), 128'(stall_o));
        check("s0_found_o", 128'(1'b0), 128'(s0_found_o));
        check("s1_found_o", 128'(1'b0), 128'(s1_found_o));
        read_all();
    endtask

    task automatic run_stim(int fd);
        logic [7:0]  cmd;
        logic [31:0] f [11];
        tlb_entry_t  ent;
        int          code;
        int          ch;
        int          r;
        code = $fscanf(fd, " %c", cmd);
        while (code == 1) begin
            case (cmd)
                "#": begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
                "W": begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                   f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                    expect_fields(code, 11, cmd);
                    ent.e          = f[1][0];
                    ent.data.vppn  = f[2][18:0];
                    ent.data.ps    = f[3][5:0];
                    ent.data.g     = f[4][0];
                    ent.data.asid  = f[5][9:0];
                    ent.data.half0 = make_half(f[6], f[7]);
                    ent.data.half1 = make_half(f[8], f[9]);
                    if (f[10][0]) begin  // random ppn and mat
                        r = $random(seed);
                        ent.data.half0.ppn = r[19:0];
                        ent.data.half0.mat = r[21:20];
                        r = $random(seed);
                        ent.data.half1.ppn = r[19:0];
                        ent.data.half1.mat = r[21:20];
                    end
                    do_write(f[0][4:0], ent);
                end
                "R": begin
                    code = $fscanf(fd, "%h", f[0]);
                    expect_fields(code, 1, cmd);
                    read_check(f[0][4:0]);
                end
                "S": begin
                    code = $fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                    expect_fields(code, 6, cmd);
                    do_search(int'(f[0]), f[1][18:0], f[2][0], f[3][9:0], f[4][0], f[5][4:0]);
                end
                "I": begin
                    code = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
                    expect_fields(code, 4, cmd);
                    do_inval(f[0][4:0], f[1][9:0], f[2][18:0], f[3][5:0]);
                end
                "Z": apply_reset();
                default: begin
                    n_errors++;
                    $display("unknown command %c in the stimulus file", cmd);
                end
            endcase
            code = $fscanf(fd, " %c", cmd);
        end
    endtask

    initial begin
        int fd;
        int ch;
        rst_n_i       = 1'b0;
        s0_fetch_i    = 1'b0;
        s0_vppn_i     = '0;
        s0_odd_page_i = 1'b0;
        s0_asid_i     = '0;
        s1_fetch_i    = 1'b0;
        s1_vppn_i     = '0;
        s1_odd_page_i = 1'b0;
        s1_asid_i     = '0;
        we_i          = 1'b0;
        w_index_i     = '0;
        w_entry_i     = '0;
        r_index_i     = '0;
        inv_en_i      = 1'b0;
        inv_op_i      = inv_all0;
        inv_asid_i    = '0;
        inv_vpn_i     = '0;
        for (int i = 0; i < tlb_num; i++) begin
            model[i]   = '0;
            written[i] = 1'b0;
        end
        fd = $fopen("verification/tlb_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file verification/tlb_stim.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            ch = $fgetc(fd);
            while (ch != -1) begin
                if (ch == 10) n_lines++;
                ch = $fgetc(fd);
            end
            $fclose(fd);
            fd = $fopen("verification/tlb_stim.txt", "r");
            run_stim(fd);
            $fclose(fd);
            $display("checks %0d, errors %0d", n_checks, n_errors);
            if (n_errors == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

    // about 20 cycles per stimulus line plus some slack
    initial begin
        wait (n_lines > 0);
        #(n_lines * 20 * 40 + 2000);
        $display("timeout, the stimulus did not finish in time for %0d lines", n_lines);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/tlb_entry.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_entry (
    input  wire                              clk,
    input  wire                              rst_n_i,

    // search port 0, result one cycle after fetch
    input  wire                              s0_fetch_i,
    input  wire [18:0]                       s0_vppn_i,
    input  wire                              s0_odd_page_i,
    input  wire [9:0]                        s0_asid_i,
    output logic                             s0_found_o,
    output logic [tlb_pkg::idx_w-1:0]        s0_index_o,
    output logic [5:0]                       s0_ps_o,
    output logic [19:0]                      s0_ppn_o,
    output logic                             s0_v_o,
    output logic                             s0_d_o,
    output logic [1:0]                       s0_mat_o,
    output logic [1:0]                       s0_plv_o,

    // search port 1
    input  wire                              s1_fetch_i,
    input  wire [18:0]                       s1_vppn_i,
    input  wire                              s1_odd_page_i,
    input  wire [9:0]                        s1_asid_i,
    output logic                             s1_found_o,
    output logic [tlb_pkg::idx_w-1:0]        s1_index_o,
    output logic [5:0]                       s1_ps_o,
    output logic [19:0]                      s1_ppn_o,
    output logic                             s1_v_o,
    output logic                             s1_d_o,
    output logic [1:0]                       s1_mat_o,
    output logic [1:0]                       s1_plv_o,

    input  wire                              we_i,
    input  wire [tlb_pkg::idx_w-1:0]         w_index_i,
    input  wire tlb_pkg::tlb_entry_t         w_entry_i,
    input  wire [tlb_pkg::idx_w-1:0]         r_index_i,
    output tlb_pkg::tlb_entry_t              r_entry_o,

    input  wire                              inv_en_i,
    input  wire tlb_op_pkg::inv_op_e         inv_op_i,
    input  wire [9:0]                        inv_asid_i,
    input  wire [18:0]                       inv_vpn_i,
    output logic                             stall_o
);
    import tlb_pkg::*;
    import tlb_op_pkg::*;

    logic [tlb_num-1:0]          e_q;
    logic [nway-1:0]             s0_e;
    logic [nway-1:0]             s1_e;
    tlb_data_t [nway-1:0]        s0_way_data;
    tlb_data_t [nway-1:0]        s1_way_data;
    tlb_data_t [nway-1:0]        rd_way;
    logic [nway-1:0]             inv_hit;
    logic [set_w-1:0]            sweep_set;
    logic                        step;
    logic                        clear;
    logic                        last;
    logic                        sweep_act;

    function automatic logic inv_clear(tlb_data_t ent, inv_op_e op,
                                       logic [9:0] asid, logic [18:0] vpn);
        logic asid_eq;
        logic va_eq;
        asid_eq = (ent.asid == asid);
        va_eq   = va_match(ent, vpn);
        case (op)
            inv_all0, inv_all1: inv_clear = 1'b1;
            inv_glob:           inv_clear = ent.g;
            inv_nglob:          inv_clear = !ent.g;
            inv_asid:           inv_clear = !ent.g && asid_eq;
            inv_asid_va:        inv_clear = !ent.g && asid_eq && va_eq;
            inv_gasid_va:       inv_clear = (ent.g || asid_eq) && va_eq;
            default:            inv_clear = 1'b0;
        endcase
    endfunction

    tlb_way_if way_if [nway] ();

    for (genvar w = 0; w < nway; w++) begin : g_way
        assign way_if[w].we         = we_i && (w_index_i[idx_w-1:set_w] == way_w'(w));
        assign way_if[w].waddr      = w_index_i[set_w-1:0];
        assign way_if[w].wdata      = w_entry_i.data;
        assign way_if[w].raddr      = r_index_i[set_w-1:0];
        assign way_if[w].sweep_addr = sweep_set;
        assign rd_way[w]            = way_if[w].rdata;
        assign inv_hit[w] = inv_clear(way_if[w].sweep_data, inv_op_i, inv_asid_i, inv_vpn_i);

        // e bits of the looked-up set only
        assign s0_e[w] = e_q[{way_w'(w), s0_vppn_i[set_w-1:0]}];
        assign s1_e[w] = e_q[{way_w'(w), s1_vppn_i[set_w-1:0]}];

        tlb_lutram u_lutram (
            .clk       (clk),
            .way       (way_if[w].ram),
            .s0_addr_i (s0_vppn_i[set_w-1:0]),
            .s1_addr_i (s1_vppn_i[set_w-1:0]),
            .s0_data_o (s0_way_data[w]),
            .s1_data_o (s1_way_data[w])
        );
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            e_q <= '0;
        end else begin
            if (sweep_act) begin
                for (int w = 0; w < nway; w++) begin
                    if (inv_hit[w]) begin
                        e_q[{way_w'(w), sweep_set}] <= 1'b0;
                    end
                end
            end
            if (we_i) begin
                e_q[w_index_i] <= w_entry_i.e;  // last one wins, so write beats a clear
            end
        end
    end

    always_comb begin
        r_entry_o.e    = e_q[r_index_i];
        r_entry_o.data = rd_way[r_index_i[idx_w-1:set_w]];
    end

    tlb_set_counter u_set_counter (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clear_i (clear),
        .step_i  (step),
        .set_o   (sweep_set),
        .last_o  (last)
    );

    tlb_inv_fsm u_inv_fsm (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .inv_en_i (inv_en_i),
        .last_i   (last),
        .step_o   (step),
        .clear_o  (clear),
        .sweep_o  (sweep_act),
        .stall_o  (stall_o)
    );

    tlb_search u_search0 (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fetch_i    (s0_fetch_i),
        .vppn_i     (s0_vppn_i),
        .odd_page_i (s0_odd_page_i),
        .asid_i     (s0_asid_i),
        .e_i        (s0_e),
        .way_data_i (s0_way_data),
        .found_o    (s0_found_o),
        .index_o    (s0_index_o),
        .ps_o       (s0_ps_o),
        .ppn_o      (s0_ppn_o),
        .v_o        (s0_v_o),
        .d_o        (s0_d_o),
        .mat_o      (s0_mat_o),
        .plv_o      (s0_plv_o)
    );

    tlb_search u_search1 (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fetch_i    (s1_fetch_i),
        .vppn_i     (s1_vppn_i),
        .odd_page_i (s1_odd_page_i),
        .asid_i     (s1_asid_i),
        .e_i        (s1_e),
        .way_data_i (s1_way_data),
        .found_o    (s1_found_o),
        .index_o    (s1_index_o),
        .ps_o       (s1_ps_o),
        .ppn_o      (s1_ppn_o),
        .v_o        (s1_v_o),
        .d_o        (s1_d_o),
        .mat_o      (s1_mat_o),
        .plv_o      (s1_plv_o)
    );

endmodule

`default_nettype wire

// ==== design/tlb_search.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_search (
    input  wire                                          clk,
    input  wire                                          rst_n_i,
    input  wire                                          fetch_i,
    input  wire [18:0]                                   vppn_i,
    input  wire                                          odd_page_i,
    input  wire [9:0]                                    asid_i,
    input  wire [tlb_pkg::nway-1:0]                      e_i,
    input  wire tlb_pkg::tlb_data_t [tlb_pkg::nway-1:0]  way_data_i,
    output logic                                         found_o,
    output logic [tlb_pkg::idx_w-1:0]                    index_o,
    output logic [5:0]                                   ps_o,
    output logic [19:0]                                  ppn_o,
    output logic                                         v_o,
    output logic                                         d_o,
    output logic [1:0]                                   mat_o,
    output logic [1:0]                                   plv_o
);
    import tlb_pkg::*;

    logic [nway-1:0]  hit;
    logic [way_w-1:0] hit_way;
    tlb_data_t        win;
    logic             odd_sel;
    tlb_half_t        half_sel;

    logic             found_q;
    logic [idx_w-1:0] index_q;
    logic [5:0]       ps_q;
    tlb_half_t        half_q;

    always_comb begin
        for (int w = 0; w < nway; w++) begin
            hit[w] = e_i[w] && va_match(way_data_i[w], vppn_i)
                     && (way_data_i[w].g || (way_data_i[w].asid == asid_i));
        end
    end

    // lowest way wins on a multi-hit
    always_comb begin
        hit_way = '0;
        for (int w = nway - 1; w >= 0; w--) begin
            if (hit[w]) begin
                hit_way = way_w'(w);
            end
        end
    end

    assign win      = way_data_i[hit_way];
    assign odd_sel  = (win.ps == ps_small) ? odd_page_i : vppn_i[8];
    assign half_sel = odd_sel ? win.half1 : win.half0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            found_q <= 1'b0;
        end else if (fetch_i) begin
            found_q <= |hit;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_i) begin
            index_q <= {hit_way, vppn_i[set_w-1:0]};
            ps_q    <= win.ps;
            half_q  <= half_sel;
        end
    end

    assign found_o = found_q;
    assign index_o = index_q;
    assign ps_o    = ps_q;
    assign ppn_o   = half_q.ppn;
    assign v_o     = half_q.v;
    assign d_o     = half_q.d;
    assign mat_o   = half_q.mat;
    assign plv_o   = half_q.plv;

endmodule

`default_nettype wire

// ==== design/tlb_inv_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_inv_fsm (
    input  wire  clk,
    input  wire  rst_n_i,
    input  wire  inv_en_i,
    input  wire  last_i,
    output logic step_o,
    output logic clear_o,
    output logic sweep_o,
    output logic stall_o
);

    typedef enum logic [1:0] {
        idle,
        sweep,
        done
    } state_e;

    state_e state_q;
    state_e state_d;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        step_o  = 1'b0;
        clear_o = 1'b0;
        sweep_o = 1'b0;
        case (state_q)
            idle: begin
                if (inv_en_i) begin  // set 0 is cleared in this very cycle
                    sweep_o = 1'b1;
                    step_o  = 1'b1;
                    state_d = sweep;
                end else begin
                    clear_o = 1'b1;
                end
            end
            sweep: begin
                sweep_o = 1'b1;
                step_o  = 1'b1;
                if (last_i) begin
                    state_d = done;
                end
            end
            done: begin
                clear_o = 1'b1;
                // wait for the requester to drop the level
                if (!inv_en_i) begin
                    state_d = idle;
                end
            end
            default: state_d = idle;
        endcase
    end

    assign stall_o = sweep_o;

endmodule

`default_nettype wire

// ==== design/tlb_set_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_set_counter (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          clear_i,
    input  wire                          step_i,
    output logic [tlb_pkg::set_w-1:0]    set_o,
    output logic                         last_o
);
    import tlb_op_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            set_o <= '0;
        end else if (clear_i) begin
            set_o <= '0;
        end else if (step_i) begin
            set_o <= set_o + 1'b1;  // wraps after the last set
        end
    end

    assign last_o = (set_o == tlb_pkg::set_w'(sweep_len - 1));

endmodule

`default_nettype wire

// ==== design/tlb_lutram.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_lutram (
    input  wire                          clk,
    tlb_way_if.ram                       way,
    input  wire [tlb_pkg::set_w-1:0]     s0_addr_i,
    input  wire [tlb_pkg::set_w-1:0]     s1_addr_i,
    output tlb_pkg::tlb_data_t           s0_data_o,
    output tlb_pkg::tlb_data_t           s1_data_o
);
    import tlb_pkg::*;

    tlb_data_t mem [nset];

    always_ff @(posedge clk) begin
        if (way.we) begin
            mem[way.waddr] <= way.wdata;
        end
    end

    // all reads are combinational
    assign way.rdata      = mem[way.raddr];
    assign way.sweep_data = mem[way.sweep_addr];
    assign s0_data_o      = mem[s0_addr_i];
    assign s1_data_o      = mem[s1_addr_i];

endmodule

`default_nettype wire

// ==== design/tlb_way_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface tlb_way_if;
    import tlb_pkg::*;

    logic             we;
    logic [set_w-1:0] waddr;
    tlb_data_t        wdata;
    logic [set_w-1:0] raddr;
    tlb_data_t        rdata;       // async
    logic [set_w-1:0] sweep_addr;  // from the set counter
    tlb_data_t        sweep_data;

    modport ctrl (
        output we, waddr, wdata, raddr, sweep_addr,
        input  rdata, sweep_data
    );

    modport ram (
        input  we, waddr, wdata, raddr, sweep_addr,
        output rdata, sweep_data
    );

endinterface

`default_nettype wire

// ==== design/tlb_op_pkg.sv ====
`default_nettype none

package tlb_op_pkg;

    typedef enum logic [4:0] {
        inv_all0     = 5'd0,
        inv_all1     = 5'd1,
        inv_glob     = 5'd2,  // g=1 only
        inv_nglob    = 5'd3,  // g=0 only
        inv_asid     = 5'd4,
        inv_asid_va  = 5'd5,
        inv_gasid_va = 5'd6
    } inv_op_e;

    // one set per cycle
    localparam int sweep_len = 8;

endpackage

`default_nettype wire

// ==== design/tlb_pkg.sv ====
`default_nettype none

package tlb_pkg;

    localparam int tlb_num = 32;
    localparam int nway    = 4;
    localparam int nset    = 8;
    localparam int idx_w   = 5;
    localparam int set_w   = 3;
    localparam int way_w   = idx_w - set_w;  // way sits above the set in an index

    localparam logic [5:0] ps_small = 6'd12;
    localparam logic [5:0] ps_huge  = 6'd21;

    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_half_t;

    // stored part of an entry, e lives in flops at the top
    typedef struct packed {
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic        g;
        logic [9:0]  asid;
        tlb_half_t   half0;
        tlb_half_t   half1;
    } tlb_data_t;

    typedef struct packed {
        logic      e;
        tlb_data_t data;
    } tlb_entry_t;

    // 2 MB pages ignore vppn[8:0]
    function automatic logic va_match(tlb_data_t ent, logic [18:0] vppn);
        logic small_eq;
        logic huge_eq;
        small_eq = (ent.ps == ps_small) && (ent.vppn == vppn);
        huge_eq  = (ent.ps == ps_huge) && (ent.vppn[18:9] == vppn[18:9]);
        return small_eq || huge_eq;
    endfunction

endpackage

`default_nettype wire
